// ==== coord_map.sv ====
/* Maps screen position to signed graph coordinates, one cycle of latency
   x carries a lead of X_LEAD pixels so the curve lines up with the delayed syncs */
`timescale 1ns/10ps

module coord_map (
    input  logic                        clk_pix,
    input  logic                        rst,
    input  logic [graph_pkg::CORDW-1:0] sx,
    input  logic [graph_pkg::CORDW-1:0] sy,
    output graph_pkg::graph_pt_t        pt
);

    graph_pkg::graph_pt_t pt_next;

    always_comb begin
        // Origin at X_OFFS, positive x to the right
        pt_next.x = graph_pkg::coord_t'(sx - graph_pkg::X_OFFS + graph_pkg::X_LEAD);
        // Origin at Y_OFFS, y grows upward so subtract sy
        pt_next.y = graph_pkg::coord_t'(graph_pkg::Y_OFFS - sy);
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            pt <= '0;
        end else begin
            pt <= pt_next;
        end
    end

endmodule

// ==== curve_test.sv ====
/* Three-stage test of y == (x*x) >> CURVE_SHIFT, one point accepted per cycle
   Negative y never matches. Result appears CURVE_LAT cycles after pt */
`timescale 1ns/10ps

module curve_test (
    input  logic                 clk_pix,
    input  logic                 rst,
    input  graph_pkg::graph_pt_t pt,
    output logic                 on_curve
);

    graph_pkg::graph_pt_t              pt_s1;   // Stage 1 point
    logic [2*graph_pkg::CORDW-1:0]     sq_s2;   // Stage 2 x squared
    graph_pkg::coord_t                 y_s2;    // Stage 2 y carried along
    logic [2*graph_pkg::CORDW-1:0]     sq_shr;  // Scaled square
    logic [2*graph_pkg::CORDW-1:0]     y_ext;   // y widened for compare

    always_comb begin
        sq_shr = sq_s2 >> graph_pkg::CURVE_SHIFT;
        y_ext  = {{graph_pkg::CORDW{1'b0}}, y_s2};  // Zero extend, sign tested apart
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            pt_s1    <= '0;
            sq_s2    <= '0;
            y_s2     <= '0;
            on_curve <= 1'b0;
        end else begin
            // Stage 1 registers the point
            pt_s1    <= pt;
            // Stage 2 squares x, signed so the result is never negative
            sq_s2    <= pt_s1.x * pt_s1.x;
            y_s2     <= pt_s1.y;
            // Stage 3 compares, negative y rejected by its sign bit
            on_curve <= !y_s2[graph_pkg::CORDW-1] && (sq_shr == y_ext);
        end
    end

    // Pipeline stays quiet through a held reset
    quiet_in_reset: assert property (@(posedge clk_pix)
        (rst && $past(rst)) |-> (on_curve !== 1'b1));

    // Origin of the graph is always on the curve, three cycles on
    origin_hits: assert property (@(posedge clk_pix) disable iff (rst)
        (pt == '0) ##1 !rst [*graph_pkg::CURVE_LAT - 1] |=> on_curve);

endmodule

// ==== display_timing.sv ====
/* 720p raster counter with active video at the start of each line and frame
   ctl is registered with sx/sy and always describes the current position. axes stays 0 */
`timescale 1ns/10ps

module display_timing (
    input  logic                        clk_pix,
    input  logic                        rst,
    output logic [graph_pkg::CORDW-1:0] sx,   // Horizontal position
    output logic [graph_pkg::CORDW-1:0] sy,   // Vertical position
    output graph_pkg::video_ctl_t       ctl
);

    logic [graph_pkg::CORDW-1:0] sx_next, sy_next;
    logic                        line_end;       // Last pixel of line
    logic                        frame_end;      // Last line of frame
    graph_pkg::video_ctl_t       ctl_next;

    // Next raster position
    always_comb begin
        line_end  = (sx == graph_pkg::H_TOTAL - 1);
        frame_end = (sy == graph_pkg::V_TOTAL - 1);
        sx_next   = line_end ? '0 : sx + 1'b1;
        sy_next   = sy;
        if (line_end) begin
            sy_next = frame_end ? '0 : sy + 1'b1;  // Wrap at end of frame
        end
    end

    // Decode syncs from the position being loaded
    always_comb begin
        ctl_next.hsync = (sx_next >= graph_pkg::H_SYNC_START)
                      && (sx_next <  graph_pkg::H_SYNC_END);
        ctl_next.vsync = (sy_next >= graph_pkg::V_SYNC_START)
                      && (sy_next <  graph_pkg::V_SYNC_END);
        ctl_next.de    = (sx_next < graph_pkg::H_ACTIVE)
                      && (sy_next < graph_pkg::V_ACTIVE);
        ctl_next.axes  = 1'b0;                   // Set later in graph_top
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx  <= '0;
            sy  <= '0;
            ctl <= '0;               // Blank until first count
        end else begin
            sx  <= sx_next;
            sy  <= sy_next;
            ctl <= ctl_next;         // Same edge as counters
        end
    end

    // Counters stay inside the raster
    sx_in_raster: assert property (@(posedge clk_pix) disable iff (rst)
        sx < graph_pkg::H_TOTAL && sy < graph_pkg::V_TOTAL);

endmodule

// ==== graph_pkg.sv ====
/* Constants and types for the 1280x720 graphing pipeline, one pixel per clk_pix
   Syncs are active high. Graph origin sits at screen (X_OFFS, Y_OFFS), y grows upward */
package graph_pkg;

    localparam int CORDW = 12;            // Screen and graph coordinate width

    // Horizontal timing in pixels
    localparam int H_ACTIVE = 1280;
    localparam int H_FP     = 110;        // Front porch
    localparam int H_SYNC   = 40;
    localparam int H_BP     = 220;        // Back porch
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;  // 1650
    localparam int H_SYNC_START = H_ACTIVE + H_FP;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;

    // Vertical timing in lines
    localparam int V_ACTIVE = 720;
    localparam int V_FP     = 5;
    localparam int V_SYNC   = 5;
    localparam int V_BP     = 20;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;  // 750
    localparam int V_SYNC_START = V_ACTIVE + V_FP;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    // Screen position of graph origin
    localparam int X_OFFS = 640;
    localparam int Y_OFFS = 359;          // One line above centre

    localparam int CURVE_SHIFT = 8;       // y = (x*x) >> CURVE_SHIFT
    localparam int CURVE_LAT   = 3;       // curve_test pipeline depth
    localparam int X_LEAD      = CURVE_LAT + 1;  // x lead for curve and mapping latency
    localparam int CTL_LAT     = CURVE_LAT + 1;  // Sync delay to meet on_curve

    typedef logic signed [CORDW-1:0] coord_t;  // Signed graph coordinate

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } graph_pt_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;                         // Active video
        logic axes;                       // Pixel on x or y axis
    } video_ctl_t;

    // Colours as 24-bit RGB
    localparam rgb_t COL_BG    = rgb_t'(24'h222222);
    localparam rgb_t COL_CURVE = rgb_t'(24'h33BBCC);
    localparam rgb_t COL_AXIS  = rgb_t'(24'hCCCCCC);

endpackage

// ==== graph_top.sv ====
/* Graphing pipeline top with parallel DVI-style outputs, no clock generation or TMDS
   Colour at the outputs trails its raster position by five clk_pix cycles */
`timescale 1ns/10ps

module graph_top (
    input  logic            clk_pix,
    input  logic            rst,
    output graph_pkg::rgb_t rgb,
    output logic            hsync,
    output logic            vsync,
    output logic            de
);

    logic [graph_pkg::CORDW-1:0] sx, sy;       // Raster position
    graph_pkg::video_ctl_t       ctl_raw;      // From timing, axes clear
    graph_pkg::video_ctl_t       ctl_tag;      // With axis flag
    graph_pkg::video_ctl_t       ctl_dly;      // Aligned with on_curve
    graph_pkg::graph_pt_t        pt;           // Graph coordinates
    logic                        on_curve;

    display_timing timing_inst (
        .clk_pix (clk_pix),
        .rst     (rst),
        .sx      (sx),
        .sy      (sy),
        .ctl     (ctl_raw)
    );

    // Axis flag from the same-cycle position
    always_comb begin
        ctl_tag      = ctl_raw;
        ctl_tag.axes = (sy == graph_pkg::Y_OFFS) || (sx == graph_pkg::X_OFFS);
    end

    coord_map map_inst (
        .clk_pix (clk_pix),
        .rst     (rst),
        .sx      (sx),
        .sy      (sy),
        .pt      (pt)
    );

    curve_test curve_inst (
        .clk_pix  (clk_pix),
        .rst      (rst),
        .pt       (pt),
        .on_curve (on_curve)
    );

    // Mapping plus curve latency
    sig_delay #(
        .T     (graph_pkg::video_ctl_t),
        .DEPTH (graph_pkg::CTL_LAT)
    ) ctl_delay_inst (
        .clk_pix (clk_pix),
        .rst     (rst),
        .d       (ctl_tag),
        .q       (ctl_dly)
    );

    pixel_shade shade_inst (
        .clk_pix  (clk_pix),
        .rst      (rst),
        .ctl      (ctl_dly),
        .on_curve (on_curve),
        .rgb      (rgb),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de)
    );

endmodule

// ==== pixel_shade.sv ====
/* Picks the pixel colour and registers it with the syncs, one cycle of latency
   Axis beats curve, curve beats background. Black outside active video */
`timescale 1ns/10ps

module pixel_shade (
    input  logic                  clk_pix,
    input  logic                  rst,
    input  graph_pkg::video_ctl_t ctl,
    input  logic                  on_curve,
    output graph_pkg::rgb_t       rgb,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  de
);

    graph_pkg::rgb_t colour;               // Unregistered colour choice

    always_comb begin
        if (!ctl.de) begin
            colour = '0;                   // Blanking
        end else if (ctl.axes) begin
            colour = graph_pkg::COL_AXIS;
        end else if (on_curve) begin
            colour = graph_pkg::COL_CURVE;
        end else begin
            colour = graph_pkg::COL_BG;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            rgb   <= '0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
        end else begin
            rgb   <= colour;
            hsync <= ctl.hsync;            // Syncs keep pace with colour
            vsync <= ctl.vsync;
            de    <= ctl.de;
        end
    end

    // No colour leaks into blanking
    black_when_blank: assert property (@(posedge clk_pix)
        !de |-> (rgb == '0));

endmodule

// ==== sig_delay.sv ====
/* Fixed-depth delay line for any packed payload T, cleared to zero on reset
   DEPTH must be at least 1 */
`timescale 1ns/10ps

module sig_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 4               // Cycles from d to q
) (
    input  logic clk_pix,
    input  logic rst,
    input  T     d,
    output T     q
);

    T stage [DEPTH];                       // stage[0] nearest the input

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];    // Shift one place per clock
            end
        end
    end

    assign q = stage[DEPTH-1];

endmodule

// ==== sim.f ====
graph_pkg.sv
display_timing.sv
coord_map.sv
curve_test.sv
sig_delay.sv
pixel_shade.sv
graph_top.sv
tb_graph.sv

// ==== tb_graph.sv ====
/* Testbench for graph_top, checks the raster and every active pixel against a reference
   Frame 1 after reset starts with a blank first pixel, so its line 0 is left out of the sums */
`timescale 1ns/10ps

module tb_graph;

    localparam int FRAME_CYCLES   = graph_pkg::H_TOTAL * graph_pkg::V_TOTAL;
    localparam int TIMEOUT_CYCLES = 2 * FRAME_CYCLES + 2000;  // Two frames plus margin

    logic            clk_pix = 1'b0;
    logic            rst     = 1'b1;
    graph_pkg::rgb_t rgb;
    logic            hsync, vsync, de;

    int          errs [1:6];                     // Errors per test
    string       test_name [1:6];
    int          n_checks = 0;
    int          cycle_cnt = 0;
    bit          done = 1'b0;                    // Frame repeat check complete
    logic        de_q = 1'b0, hs_q = 1'b0, vs_q = 1'b0;  // Previous samples
    int          px, line;                       // Tracked raster position
    int          run_len, hs_len, vs_len;
    int          hs_pulses = 0;                  // hsync pulses in the checked frame
    int          vs_seen = 0;                    // vsync pulses after reset
    int          quiet_left = 0;
    int          repeat_lines = 0, curve_pix = 0, total_errs;
    logic [31:0] line_sum;
    logic [31:0] sum_mem [graph_pkg::V_ACTIVE];  // Per-line checksums
    bit          sum_ok  [graph_pkg::V_ACTIVE];
    graph_pkg::rgb_t exp_rgb;

    graph_top dut (
        .clk_pix (clk_pix),
        .rst     (rst),
        .rgb     (rgb),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de)
    );

    initial begin
        forever begin
            #10 clk_pix = 1'b1;                  // 20 ns period
            #10 clk_pix = 1'b0;
        end
    end

    always @(posedge clk_pix) cycle_cnt <= cycle_cnt + 1;

    // Expected colour of an active pixel
    function automatic graph_pkg::rgb_t expected_rgb(input int col, input int row);
        int gx, gy;
        gx = col - graph_pkg::X_OFFS + graph_pkg::CURVE_LAT + 1;  // Curve runs ahead by the lead
        gy = graph_pkg::Y_OFFS - row;                              // Up is positive
        if (col == graph_pkg::X_OFFS || row == graph_pkg::Y_OFFS) begin
            return graph_pkg::COL_AXIS;
        end else if (gy >= 0 && ((gx * gx) >> graph_pkg::CURVE_SHIFT) == gy) begin
            return graph_pkg::COL_CURVE;
        end else begin
            return graph_pkg::COL_BG;
        end
    endfunction

    task automatic check_value(input int id, input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        n_checks++;
        if (got !== exp) begin
            errs[id]++;
            $display("** Error at %0t ns: test %0d %s, got %h expected %h",
                     $time, id, what, got, exp);
        end
    endtask

    task automatic report_test(input int id);
        $display("Test %0d %s: %s, %0d errors", id, test_name[id],
                 (errs[id] == 0) ? "ok" : "failed", errs[id]);
    endtask

    // Compare process, samples at the falling edge where outputs are settled
    always @(negedge clk_pix) begin
        if (rst) begin
            check_value(1, {hsync, vsync, de}, 3'b000, "syncs active in reset");
            check_value(1, {8'h00, rgb}, 32'h0, "rgb not black in reset");
            quiet_left = 5;
            px         = 0;
            line       = 0;                      // Frame 1 counted from reset
            run_len    = 0;
            hs_len     = 0;
            vs_len     = 0;
        end else begin
            if (quiet_left > 0) begin
                check_value(1, {hsync, vsync, de}, 3'b000, "syncs active after release");
                check_value(1, {8'h00, rgb}, 32'h0, "rgb not black after release");
                quiet_left--;
                if (quiet_left == 0) report_test(1);
            end
            if (!de) check_value(3, {8'h00, rgb}, 32'h0, "rgb not black in blanking");

            // hsync pulse width
            if (hsync && !hs_q) hs_len = 1;
            else if (hsync) hs_len++;
            if (!hsync && hs_q && vs_seen == 1) begin
                check_value(2, hs_len, graph_pkg::H_SYNC, "hsync width");
                hs_pulses++;
            end

            // vsync pulse width in cycles, then line count per frame
            if (vsync && !vs_q) vs_len = 1;
            else if (vsync) vs_len++;
            if (!vsync && vs_q && vs_seen == 1) begin
                check_value(2, vs_len, graph_pkg::V_SYNC * graph_pkg::H_TOTAL, "vsync width");
            end
            if (vsync && !vs_q) begin
                if (vs_seen == 1) begin
                    check_value(2, line, graph_pkg::V_ACTIVE, "de runs per frame");
                    check_value(2, hs_pulses, graph_pkg::V_TOTAL, "hsync pulses per frame");
                end
                vs_seen++;
                line = 0;                        // Next de run is line 0
                if (vs_seen == 2) report_test(2);
            end

            if (de && !de_q) begin               // Start of an active run
                px       = 0;
                run_len  = 0;
                line_sum = '0;
            end
            if (de) begin
                if (vs_seen >= 1 && line < graph_pkg::V_ACTIVE) begin
                    exp_rgb = expected_rgb(px, line);
                    if (exp_rgb == graph_pkg::COL_AXIS) begin
                        check_value(4, {8'h00, rgb}, {8'h00, exp_rgb}, "axis pixel");
                    end else begin
                        check_value(5, {8'h00, rgb}, {8'h00, exp_rgb}, "graph pixel");
                    end
                    if (rgb == graph_pkg::COL_CURVE) curve_pix++;
                end
                line_sum = {line_sum[30:0], line_sum[31]} ^ {8'h00, rgb};  // Rotate and fold
                px++;
                run_len++;
            end

            if (!de && de_q) begin               // End of an active run
                if (vs_seen == 1) check_value(2, run_len, graph_pkg::H_ACTIVE, "de run length");
                if (run_len == graph_pkg::H_ACTIVE && line < graph_pkg::V_ACTIVE) begin
                    if (sum_ok[line]) begin
                        check_value(6, line_sum, sum_mem[line], "line checksum");
                        repeat_lines++;
                    end
                    sum_mem[line] = line_sum;
                    sum_ok[line]  = 1'b1;
                end
                line++;
                if (repeat_lines >= graph_pkg::V_ACTIVE) done = 1'b1;
            end
        end
        de_q = de;
        hs_q = hsync;
        vs_q = vsync;
    end

    initial begin
        for (int i = 1; i <= 6; i++) errs[i] = 0;
        test_name[1] = "reset quiet";
        test_name[2] = "raster geometry";
        test_name[3] = "blanking";
        test_name[4] = "axes";
        test_name[5] = "curve and background";
        test_name[6] = "frame repeat";
        repeat (16) @(posedge clk_pix);
        rst <= 1'b0;                             // Release on a rising edge
        while (!done && cycle_cnt < TIMEOUT_CYCLES) @(posedge clk_pix);
        if (!done) begin
            $display("Timeout: frame repeat not complete after %0d cycles, %0d lines compared",
                     cycle_cnt, repeat_lines);
            $display("TESTBENCH FAILED");
        end else begin
            check_value(5, curve_pix != 0, 1, "no curve pixels seen");
            for (int i = 3; i <= 6; i++) report_test(i);
            total_errs = 0;
            for (int i = 1; i <= 6; i++) total_errs += errs[i];
            $display("Tests 6, checks %0d, errors %0d, curve pixels %0d, lines compared %0d",
                     n_checks, total_errs, curve_pix, repeat_lines);
            if (total_errs == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
        end
        $finish;
    end

endmodule
